// ==== src/mipsPkg.sv ====
package mipsPkg;

    //////////////////////////////////////////////////
    // Widths with a meaning
    //////////////////////////////////////////////////
    typedef logic [31:0] word_t;      // Data, instructions, addresses
    typedef logic [4:0]  regAddr_t;   // Register index
    typedef logic [4:0]  shamt_t;     // Shift amount
    typedef logic [14:0] progAddr_t;  // Bit 14 picks data memory
    typedef logic [23:0] ledVal_t;    // Board LED bank
    typedef logic [3:0]  aluSel_t;

    // ALU operations
    localparam aluSel_t aluAdd  = 4'd0;  // Also the idle default
    localparam aluSel_t aluSub  = 4'd1;
    localparam aluSel_t aluAnd  = 4'd2;
    localparam aluSel_t aluOr   = 4'd3;
    localparam aluSel_t aluXor  = 4'd4;
    localparam aluSel_t aluNor  = 4'd5;
    localparam aluSel_t aluSlt  = 4'd6;
    localparam aluSel_t aluSltu = 4'd7;
    localparam aluSel_t aluLui  = 4'd8;
    localparam aluSel_t aluSll  = 4'd9;
    localparam aluSel_t aluSrl  = 4'd10;
    localparam aluSel_t aluSra  = 4'd11;

    // Decoded control, 16 bits
    typedef struct packed {
        logic    regDst;    // Write rd, not rt
        logic    aluSrc;    // Operand B from immediate
        logic    memToReg;
        logic    regWrite;
        logic    memWrite;
        logic    branch;    // beq
        logic    nBranch;   // bne
        logic    jmp;
        logic    jal;
        logic    jr;
        logic    zeroExt;   // Logical immediates
        logic    shiftVar;  // Shift by rs
        aluSel_t aluSel;
    } ctrlSigs_t;

    //////////////////////////////////////////////////
    // Opcode and function fields
    //////////////////////////////////////////////////
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    // Memory-mapped I/O
    localparam word_t ledAddr    = 32'hFFFFFC60;
    localparam word_t switchAddr = 32'hFFFFFC70;

endpackage

// ==== src/instrFetch.sv ====
module instrFetch #(
    parameter int iMemWords = 1024
) (
    input  logic               fpga_clk,
    input  logic               coreRst,
    input  logic               progWe,       // Already gated for instruction side
    input  mipsPkg::progAddr_t progAddr,
    input  mipsPkg::word_t     progData,
    input  mipsPkg::ctrlSigs_t ctrl,
    input  logic               zero,
    input  mipsPkg::word_t     branchTarget,
    input  mipsPkg::word_t     readData1,    // jr target
    output mipsPkg::word_t     instr,
    output mipsPkg::word_t     pcPlus4
);
    import mipsPkg::*;

    localparam int idxBits = $clog2(iMemWords);

    word_t              iMem [iMemWords];  // Kept through reset
    word_t              pc;
    word_t              nextPc;
    word_t              jumpTarget;
    logic               takeBranch;
    logic [idxBits-1:0] pcIdx;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////
    assign pcIdx   = pc[idxBits+1:2];      // Word index, byte offset dropped
    assign instr   = iMem[pcIdx];          // Asynchronous read
    assign pcPlus4 = pc + 32'd4;

    // Loader side of the array
    always_ff @(posedge fpga_clk) begin
        if (progWe) begin
            iMem[progAddr[idxBits-1:0]] <= progData;
        end
    end

    //////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////
    assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};  // Region of PC+4
    assign takeBranch = (ctrl.branch & zero) | (ctrl.nBranch & ~zero);

    always_comb begin
        if (ctrl.jr) begin
            nextPc = readData1;            // Register jump
        end else if (ctrl.jmp || ctrl.jal) begin
            nextPc = jumpTarget;
        end else if (takeBranch) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;              // Fall through
        end
    end

    // PC register, starts at 0
    always_ff @(posedge fpga_clk) begin
        if (coreRst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== src/controlUnit.sv ====
module controlUnit (
    input  mipsPkg::word_t     instr,
    output mipsPkg::ctrlSigs_t ctrl
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;                               // Idle struct, add with no side effects
        case (opcode)
            opRtype: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd, fnAddu: ctrl.aluSel = aluAdd;  // No overflow trap
                    fnSub, fnSubu: ctrl.aluSel = aluSub;
                    fnAnd:         ctrl.aluSel = aluAnd;
                    fnOr:          ctrl.aluSel = aluOr;
                    fnXor:         ctrl.aluSel = aluXor;
                    fnNor:         ctrl.aluSel = aluNor;
                    fnSlt:         ctrl.aluSel = aluSlt;
                    fnSltu:        ctrl.aluSel = aluSltu;
                    fnSll:         ctrl.aluSel = aluSll;
                    fnSrl:         ctrl.aluSel = aluSrl;
                    fnSra:         ctrl.aluSel = aluSra;
                    fnSllv, fnSrlv, fnSrav: begin
                        ctrl.shiftVar = 1'b1;          // Amount from rs
                        ctrl.aluSel   = (funct == fnSllv) ? aluSll :
                                        (funct == fnSrlv) ? aluSrl : aluSra;
                    end
                    fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jr       = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;   // Unknown function
                endcase
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluSel = aluSub;                // Compare by subtraction
            end
            opBne: begin
                ctrl.nBranch = 1'b1;
                ctrl.aluSel  = aluSub;
            end
            opJ:   ctrl.jmp = 1'b1;
            opJal: begin
                ctrl.jal      = 1'b1;
                ctrl.regWrite = 1'b1;                // Link into $31
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.zeroExt  = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
                case (opcode)
                    opSlti:  ctrl.aluSel = aluSlt;
                    opSltiu: ctrl.aluSel = aluSltu;  // Sign-extended, unsigned compare
                    opAndi:  ctrl.aluSel = aluAnd;
                    opOri:   ctrl.aluSel = aluOr;
                    opXori:  ctrl.aluSel = aluXor;
                    opLui:   ctrl.aluSel = aluLui;
                    default: ctrl.aluSel = aluAdd;   // addi, addiu
                endcase
            end
            default: ctrl = '0;                      // Unknown opcode
        endcase
    end

endmodule

// ==== src/regDecode.sv ====
module regDecode (
    input  logic               fpga_clk,
    input  logic               coreRst,
    input  mipsPkg::word_t     instr,
    input  mipsPkg::ctrlSigs_t ctrl,
    input  mipsPkg::word_t     pcPlus4,      // Link value for jal
    input  mipsPkg::word_t     aluResult,
    input  mipsPkg::word_t     memReadData,
    output mipsPkg::word_t     readData1,
    output mipsPkg::word_t     readData2,
    output mipsPkg::word_t     immExt
);
    import mipsPkg::*;

    word_t        regs [32];
    regAddr_t     rs;
    regAddr_t     rt;
    regAddr_t     rd;
    regAddr_t     writeAddr;
    word_t        writeData;
    logic [15:0]  imm;

    // Instruction fields
    assign rs  = instr[25:21];
    assign rt  = instr[20:16];
    assign rd  = instr[15:11];
    assign imm = instr[15:0];

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////
    assign readData1 = (rs == 5'd0) ? '0 : regs[rs];  // $0 hardwired
    assign readData2 = (rt == 5'd0) ? '0 : regs[rt];

    // Zero extension only for andi, ori, xori
    assign immExt = ctrl.zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};

    //////////////////////////////////////////////////
    // Write back
    //////////////////////////////////////////////////
    always_comb begin
        if (ctrl.jal) begin
            writeAddr = 5'd31;                 // Return address register
            writeData = pcPlus4;
        end else begin
            writeAddr = ctrl.regDst ? rd : rt;
            writeData = ctrl.memToReg ? memReadData : aluResult;
        end
    end

    // Whole file cleared on reset
    always_ff @(posedge fpga_clk) begin
        if (coreRst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData;      // Writes to $0 dropped
        end
    end

endmodule

// ==== src/aluExecute.sv ====
module aluExecute (
    input  mipsPkg::word_t     instr,        // shamt field
    input  mipsPkg::ctrlSigs_t ctrl,
    input  mipsPkg::word_t     readData1,
    input  mipsPkg::word_t     readData2,
    input  mipsPkg::word_t     immExt,
    input  mipsPkg::word_t     pcPlus4,
    output mipsPkg::word_t     aluResult,
    output logic               zero,
    output mipsPkg::word_t     branchTarget
);
    import mipsPkg::*;

    word_t  opA;
    word_t  opB;
    word_t  diff;
    shamt_t shiftAmt;
    logic   ltSigned;
    logic   ltUnsigned;

    //////////////////////////////////////////////////
    // Operands
    //////////////////////////////////////////////////
    assign opA = readData1;
    assign opB = ctrl.aluSrc ? immExt : readData2;  // Immediate or rt

    // Shift amount from shamt field or low bits of rs
    assign shiftAmt = ctrl.shiftVar ? readData1[4:0] : instr[10:6];

    // Shared subtractor for sub and the zero flag
    assign diff = opA - opB;
    assign zero = (diff == '0);

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl.aluSel)
            aluAdd:  aluResult = opA + opB;            // Wraps, never traps
            aluSub:  aluResult = diff;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluXor:  aluResult = opA ^ opB;
            aluNor:  aluResult = ~(opA | opB);
            aluSlt:  aluResult = {31'b0, ltSigned};
            aluSltu: aluResult = {31'b0, ltUnsigned};
            aluLui:  aluResult = {opB[15:0], 16'b0};   // Immediate to upper half
            aluSll:  aluResult = readData2 << shiftAmt;
            aluSrl:  aluResult = readData2 >> shiftAmt;
            aluSra:  aluResult = $signed(readData2) >>> shiftAmt;
            default: aluResult = opA + opB;
        endcase
    end

    // Word offset relative to the next instruction
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};

endmodule

// ==== src/dataMemIo.sv ====
module dataMemIo #(
    parameter int dMemWords = 1024
) (
    input  logic               fpga_clk,
    input  logic               coreRst,
    input  mipsPkg::ctrlSigs_t ctrl,
    input  mipsPkg::word_t     addr,         // ALU result
    input  mipsPkg::word_t     writeData,    // rt value
    input  logic [23:0]        switch,
    input  logic               progWe,       // Already gated for data side
    input  mipsPkg::progAddr_t progAddr,
    input  mipsPkg::word_t     progData,
    output mipsPkg::word_t     memReadData,
    output mipsPkg::ledVal_t   led
);
    import mipsPkg::*;

    localparam int idxBits = $clog2(dMemWords);

    word_t              dMem [dMemWords];  // Kept through reset
    ledVal_t            ledReg;
    logic               isLed;
    logic               isSwitch;
    logic               coreStore;
    logic [idxBits-1:0] wordIdx;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    assign isLed     = (addr == ledAddr);
    assign isSwitch  = (addr == switchAddr);
    assign wordIdx   = addr[idxBits+1:2];
    assign coreStore = ctrl.memWrite & ~coreRst;  // Nothing stored while held

    // Data array, loader has priority
    always_ff @(posedge fpga_clk) begin
        if (progWe) begin
            dMem[progAddr[idxBits-1:0]] <= progData;
        end else if (coreStore && !isLed && !isSwitch) begin
            dMem[wordIdx] <= writeData;        // Switch stores fall here and are dropped
        end
    end

    // LED bank, low 24 bits of the store
    always_ff @(posedge fpga_clk) begin
        if (coreRst) begin
            ledReg <= '0;
        end else if (coreStore && isLed) begin
            ledReg <= writeData[23:0];
        end
    end

    assign led = ledReg;

    // Read mux
    always_comb begin
        if (isSwitch) begin
            memReadData = {8'b0, switch};      // Zero-extended
        end else if (isLed) begin
            memReadData = {8'b0, ledReg};
        end else begin
            memReadData = dMem[wordIdx];
        end
    end

endmodule

// ==== src/mipsTop.sv ====
module mipsTop #(
    parameter int iMemWords = 1024,
    parameter int dMemWords = 1024
) (
    input  logic               fpga_clk,
    input  logic               fpga_rst,     // Active high
    input  logic [23:0]        switch,
    output mipsPkg::ledVal_t   led,
    output mipsPkg::word_t     debug,
    input  logic               progMode,     // Holds core in reset while loading
    input  logic               progWe,
    input  mipsPkg::progAddr_t progAddr,
    input  mipsPkg::word_t     progData
);
    import mipsPkg::*;

    logic      coreRst;
    logic      instrProgWe;
    logic      dataProgWe;
    word_t     instr;
    word_t     pcPlus4;
    word_t     readData1;
    word_t     readData2;
    word_t     immExt;
    word_t     aluResult;
    word_t     branchTarget;
    word_t     memReadData;
    ctrlSigs_t ctrl;
    logic      zero;

    //////////////////////////////////////////////////
    // Reset and loader strobes
    //////////////////////////////////////////////////
    assign coreRst     = fpga_rst | progMode;
    assign instrProgWe = progMode & progWe & ~progAddr[14];  // Instruction array
    assign dataProgWe  = progMode & progWe & progAddr[14];   // Data array

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////
    instrFetch #(.iMemWords(iMemWords)) uFetch (
        .fpga_clk, .coreRst, .progWe(instrProgWe), .progAddr, .progData,
        .ctrl, .zero, .branchTarget, .readData1, .instr, .pcPlus4
    );

    controlUnit uCtrl (.instr, .ctrl);

    regDecode uDecode (
        .fpga_clk, .coreRst, .instr, .ctrl, .pcPlus4, .aluResult,
        .memReadData, .readData1, .readData2, .immExt
    );

    aluExecute uExec (
        .instr, .ctrl, .readData1, .readData2, .immExt, .pcPlus4,
        .aluResult, .zero, .branchTarget
    );

    dataMemIo #(.dMemWords(dMemWords)) uMem (
        .fpga_clk, .coreRst, .ctrl, .addr(aluResult), .writeData(readData2),
        .switch, .progWe(dataProgWe), .progAddr, .progData, .memReadData, .led
    );

    assign debug = aluResult;  // ALU result of the current instruction

endmodule

// ==== verification/mipsTb.sv ====
module mipsTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    // R-type ALU functions, shifts and immediate ops exercised in a loop
    localparam logic [59:0] aluFns = {fnAdd, fnAddu, fnSub, fnSubu, fnAnd,
                                      fnOr, fnXor, fnNor, fnSlt, fnSltu};
    localparam logic [35:0] shiftFns = {fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav};
    localparam logic [41:0] immOps = {opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opSltiu};

    logic      fpga_clk;
    logic      fpga_rst;
    logic      progMode;
    logic      progWe;
    progAddr_t progAddr;
    word_t     progData;
    logic [23:0] switch;
    ledVal_t   led;
    word_t     debug;

    word_t     prog [$];        // Code words for the next load
    word_t     preload [$];     // Data words from index 0
    word_t     mImem [1024];    // Reference machine state
    word_t     mDmem [1024];
    word_t     mRegs [32];
    word_t     mPc;
    ledVal_t   mLed;
    int        cyc;             // Compared cycles of the current program
    logic      running;

    mipsTop #(.iMemWords(1024), .dMemWords(1024)) i_dut (
        .fpga_clk, .fpga_rst, .switch, .led, .debug, .progMode, .progWe, .progAddr, .progData
    );

    initial begin : clockGen
        fpga_clk = 1'b0;
        forever #2 fpga_clk = ~fpga_clk;  // 4 ns period
    end

    //////////////////////////////////////////////////
    // Encoders and checks
    //////////////////////////////////////////////////
    function automatic word_t rInstr(int rs, int rt, int rd, int sh, logic [5:0] fn);
        return {opRtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t iInstr(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t jInstr(logic [5:0] op, int wordIdx);
        return {op, wordIdx[25:0]};      // Word index within the first region
    endfunction

    task automatic checkEqual(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Reference machine, one instruction per call
    //////////////////////////////////////////////////
    function automatic word_t refStep();
        word_t ins;
        word_t a;
        word_t b;
        word_t se;
        word_t res;
        word_t wdata;
        word_t nextPc;
        int    dst;
        logic  wr;
        ins    = mImem[mPc[11:2]];
        a      = mRegs[ins[25:21]];
        b      = mRegs[ins[20:16]];
        se     = {{16{ins[15]}}, ins[15:0]};
        res    = a + b;                  // Jumps leave the ALU adding rs and rt
        nextPc = mPc + 32'd4;
        dst    = ins[20:16];             // rt unless R-type or jal
        wr     = 1'b1;
        case (ins[31:26])
            opRtype: begin
                dst = ins[15:11];
                case (ins[5:0])
                    fnSub, fnSubu: res = a - b;
                    fnAnd:   res = a & b;
                    fnOr:    res = a | b;
                    fnXor:   res = a ^ b;
                    fnNor:   res = ~(a | b);
                    fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSltu:  res = (a < b) ? 32'd1 : 32'd0;
                    fnSll:   res = b << ins[10:6];
                    fnSrl:   res = b >> ins[10:6];
                    fnSra:   res = $signed(b) >>> ins[10:6];
                    fnSllv:  res = b << a[4:0];       // Amount from rs
                    fnSrlv:  res = b >> a[4:0];
                    fnSrav:  res = $signed(b) >>> a[4:0];
                    fnJr: begin
                        wr     = 1'b0;
                        nextPc = a;
                    end
                    default: res = a + b;    // add, addu
                endcase
            end
            opAddi, opAddiu: res = a + se;
            opAndi:  res = a & {16'b0, ins[15:0]};
            opOri:   res = a | {16'b0, ins[15:0]};
            opXori:  res = a ^ {16'b0, ins[15:0]};
            opSlti:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
            opSltiu: res = (a < se) ? 32'd1 : 32'd0;
            opLui:   res = {ins[15:0], 16'b0};
            opLw:    res = a + se;
            opBeq, opBne: begin
                wr  = 1'b0;
                res = a - b;
                if ((res == 32'd0) == (ins[31:26] == opBeq)) begin
                    nextPc = mPc + 32'd4 + (se << 2);
                end
            end
            opJ, opJal: begin
                wr     = (ins[31:26] == opJal);
                dst    = 31;                 // Link register
                nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            end
            opSw: begin
                wr  = 1'b0;
                res = a + se;
                if (res == ledAddr) begin
                    mLed = b[23:0];
                end else if (res != switchAddr) begin
                    mDmem[res[11:2]] = b;    // Switch stores vanish
                end
            end
            default: wr = 1'b0;
        endcase
        case (ins[31:26])
            opLw: wdata = (res == switchAddr) ? {8'b0, switch} :
                          (res == ledAddr) ? {8'b0, mLed} : mDmem[res[11:2]];
            opJal:   wdata = mPc + 32'd4;
            default: wdata = res;
        endcase
        if (wr && dst != 0) begin
            mRegs[dst] = wdata;
        end
        mPc = nextPc;
        return res;
    endfunction

    // Compare process, first check one cycle after progMode drops
    always @(negedge fpga_clk) begin : compare
        word_t   expAlu;
        ledVal_t expLed;
        if (running) begin
            if (cyc == 0) begin
                void'(refStep());            // Word 0 ran in the first cycle
            end
            expLed = mLed;                   // State after the previous step
            expAlu = refStep();
            checkEqual(debug, expAlu, "debug");
            checkEqual({8'b0, led}, {8'b0, expLed}, "led");
            cyc++;
        end
    end

    //////////////////////////////////////////////////
    // Loading and running
    //////////////////////////////////////////////////
    task automatic loadProgram();
        progMode <= 1'b1;                    // Core held from this edge on
        running  <= 1'b0;
        for (int i = 0; i < prog.size() + preload.size(); i++) begin
            @(negedge fpga_clk);
            checkEqual({8'b0, led}, 32'd0, "led while loading");
            progWe <= 1'b1;
            if (i < prog.size()) begin
                progAddr <= 15'(i);
                progData <= prog[i];
            end else begin
                progAddr <= 15'h4000 | 15'(i - prog.size());  // Data side
                progData <= preload[i - prog.size()];
            end
        end
        @(negedge fpga_clk);
        progWe <= 1'b0;
        switch <= 24'($urandom);
        for (int i = 0; i < prog.size(); i++) begin
            mImem[i] = prog[i];
        end
        for (int i = 0; i < preload.size(); i++) begin
            mDmem[i] = preload[i];
        end
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;                   // Cleared by the load reset
        end
        mPc      = '0;
        mLed     = '0;
        cyc      = 0;
        progMode <= 1'b0;
        running  <= 1'b1;
    endtask

    task automatic runProgram(input int steps);
        int waited;
        waited = 0;
        while (cyc < steps) begin
            @(negedge fpga_clk);
            waited++;
            if (waited > steps + 16) begin
                $display("Timeout: the compare process stopped counting cycles");
                $display("SOME TESTS FAILED");
                $fatal(1, "run stopped on timeout");
            end
        end
    endtask

    // ALU ops on random operands, then branches, calls, memory and I/O
    task automatic buildMixed();
        prog.delete();
        preload.delete();
        prog.push_back(iInstr(opLui, 0, 1, $urandom));
        prog.push_back(iInstr(opOri, 1, 1, $urandom));
        prog.push_back(iInstr(opLui, 0, 2, $urandom));
        prog.push_back(iInstr(opOri, 2, 2, $urandom));
        for (int i = 0; i < 10; i++) begin
            prog.push_back(rInstr(1, 2, 3 + i, 0, aluFns[6*i +: 6]));
        end
        // Variable shifts take the amount from the other operand register
        for (int i = 0; i < 6; i++) begin
            prog.push_back(rInstr(2 - i % 2, 1 + i % 2, 13 + i, $urandom, shiftFns[6*i +: 6]));
        end
        for (int i = 0; i < 7; i++) begin
            prog.push_back(iInstr(immOps[6*i +: 6], 1 + i % 2, 16 + i, $urandom));
        end
        prog.push_back(iInstr(opBeq, 1, 1, 1));        // Always taken
        prog.push_back(iInstr(opAddi, 0, 23, 1));      // Skipped
        prog.push_back(iInstr(opBne, 1, 2, 1));
        prog.push_back(iInstr(opAddi, 23, 23, 2));
        prog.push_back(jInstr(opJal, prog.size() + 3));
        prog.push_back(rInstr(31, 0, 24, 0, fnAdd));   // Link value on debug
        prog.push_back(jInstr(opJ, prog.size() + 3));
        prog.push_back(iInstr(opAddi, 0, 25, 5));      // Subroutine
        prog.push_back(rInstr(31, 0, 0, 0, fnJr));
        prog.push_back(iInstr(opSw, 0, 1, 8));
        prog.push_back(iInstr(opLw, 0, 26, 8));
        prog.push_back(iInstr(opLw, 0, 27, 4));        // Preloaded word 1
        prog.push_back(iInstr(opLw, 0, 28, switchAddr[15:0]));
        prog.push_back(iInstr(opSw, 0, 2, ledAddr[15:0]));
        prog.push_back(rInstr(26, 27, 29, 0, fnAdd));
        prog.push_back(iInstr(opBeq, 0, 0, -1));       // Park here
        preload.push_back($urandom);
        preload.push_back($urandom);
    endtask

    // Second load, registers cleared but data kept
    task automatic buildRestart();
        prog.delete();
        preload.delete();
        prog.push_back(iInstr(opLw, 0, 5, 8));
        prog.push_back(rInstr(1, 2, 3, 0, fnAdd));
        prog.push_back(rInstr(26, 31, 4, 0, fnOr));
        prog.push_back(iInstr(opLw, 0, 6, switchAddr[15:0]));
        prog.push_back(iInstr(opSw, 0, 6, ledAddr[15:0]));
        prog.push_back(rInstr(5, 6, 7, 0, fnXor));
        prog.push_back(iInstr(opBeq, 0, 0, -1));
    endtask

    initial begin : mainFlow
        void'($urandom(32'hec79));
        fpga_rst = 1'b1;
        progMode = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        switch   = '0;
        running  = 1'b0;
        cyc      = 0;
        repeat (8) @(negedge fpga_clk);
        fpga_rst <= 1'b0;                    // progMode rises on the same edge
        buildMixed();
        loadProgram();
        runProgram(prog.size() + 4);
        buildRestart();
        loadProgram();
        runProgram(prog.size() + 4);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== mipsTop.f ====
src/mipsPkg.sv
src/instrFetch.sv
src/controlUnit.sv
src/regDecode.sv
src/aluExecute.sv
src/dataMemIo.sv
src/mipsTop.sv
verification/mipsTb.sv

// ==== Bender.yml ====
package:
  name: mipstop

sources:
  # Package first, then the datapath blocks, then the top level
  - files:
      - src/mipsPkg.sv
      - src/instrFetch.sv
      - src/controlUnit.sv
      - src/regDecode.sv
      - src/aluExecute.sv
      - src/dataMemIo.sv
      - src/mipsTop.sv

  # Testbench, simulation only
  - target: simulation
    files:
      - verification/mipsTb.sv
